// File: src/alu_imm_params.svh
/*
  Immediate ALU pipeline sizes
  Register file, reorder buffer and data path widths
*/
`ifndef ALU_IMM_PARAMS_SVH
`define ALU_IMM_PARAMS_SVH

// Data path
`define ALU_IMM_XLEN 32

// Physical register file
`define ALU_IMM_PR_COUNT 64
`define ALU_IMM_LOG_PR_COUNT 6
`define ALU_IMM_BANK_COUNT 4
`define ALU_IMM_LOG_BANK_COUNT 2

// Reorder buffer
`define ALU_IMM_LOG_ROB_ENTRIES 5

`endif

// File: src/alu_imm_pkg.sv
/*
  Immediate ALU package
  Shared data types and operation codes of the immediate ALU pipeline
*/
`include "alu_imm_params.svh"

package alu_imm_pkg;

  typedef logic [`ALU_IMM_XLEN-1:0] word_t;
  typedef logic [11:0] imm12_t;
  typedef logic [`ALU_IMM_LOG_PR_COUNT-1:0] pr_idx_t;
  // Low bits of a physical register number
  typedef logic [`ALU_IMM_LOG_BANK_COUNT-1:0] bank_idx_t;
  typedef logic [`ALU_IMM_LOG_ROB_ENTRIES-1:0] rob_idx_t;
  typedef logic [3:0] alu_op_t;

  // Operation codes, anything else gives zero
  localparam alu_op_t OP_ADDI  = 4'd0;
  localparam alu_op_t OP_SLTI  = 4'd1;
  localparam alu_op_t OP_SLTIU = 4'd2;
  localparam alu_op_t OP_XORI  = 4'd3;
  localparam alu_op_t OP_ORI   = 4'd4;
  localparam alu_op_t OP_ANDI  = 4'd5;
  localparam alu_op_t OP_SLLI  = 4'd6;
  localparam alu_op_t OP_SRLI  = 4'd7;
  localparam alu_op_t OP_SRAI  = 4'd8;

endpackage

// File: src/prf_read_if.sv
/*
  Register file read port
  One operand read with request and acknowledge
*/
`timescale 1ns/1ps

interface prf_read_if
  import alu_imm_pkg::*;
  ();

  logic    req;
  pr_idx_t pr;
  logic    ack;
  // Valid while ack is high
  word_t   data;

  modport requester (
    output req,
    output pr,
    input  ack,
    input  data
  );

  modport responder (
    input  req,
    input  pr,
    output ack,
    output data
  );

endinterface

// File: src/wb_if.sv
/*
  Writeback bundle
  Result, destination register and ROB index with valid/ready
*/
`timescale 1ns/1ps

interface wb_if
  import alu_imm_pkg::*;
  ();

  logic     valid;
  logic     ready;
  word_t    data;
  pr_idx_t  pr;
  rob_idx_t rob_index;

  modport source (
    output valid,
    input  ready,
    output data,
    output pr,
    output rob_index
  );

  modport sink (
    input  valid,
    output ready,
    input  data,
    input  pr,
    input  rob_index
  );

  // Observes transfers without driving anything
  modport monitor (
    input valid,
    input ready,
    input data,
    input pr,
    input rob_index
  );

endinterface

// File: src/prf_banks.sv
/*
  Banked physical register file
  Combinational read with per-bank busy back-off, init and writeback writes
*/
`timescale 1ns/1ps
`include "alu_imm_params.svh"

module prf_banks
  import alu_imm_pkg::*;
(
  input  logic                           CLK,
  input  logic                           rst_n,
  input  logic [`ALU_IMM_BANK_COUNT-1:0] bank_busy,
  input  logic                           init_we,
  input  pr_idx_t                        init_pr,
  input  word_t                          init_data,
  prf_read_if.responder                  rd,
  wb_if.monitor                          wb
);

  localparam int ROWS = `ALU_IMM_PR_COUNT / `ALU_IMM_BANK_COUNT;
  localparam int ROW_W = `ALU_IMM_LOG_PR_COUNT - `ALU_IMM_LOG_BANK_COUNT;

  word_t regs [`ALU_IMM_BANK_COUNT][ROWS];

  bank_idx_t        rd_bank;
  logic [ROW_W-1:0] rd_row;
  bank_idx_t        init_bank;
  logic [ROW_W-1:0] init_row;
  bank_idx_t        wb_bank;
  logic [ROW_W-1:0] wb_row;
  logic             wb_xfer;

  // Bank from the low bits, row from the rest
  assign rd_bank   = rd.pr[`ALU_IMM_LOG_BANK_COUNT-1:0];
  assign rd_row    = rd.pr[`ALU_IMM_LOG_PR_COUNT-1:`ALU_IMM_LOG_BANK_COUNT];
  assign init_bank = init_pr[`ALU_IMM_LOG_BANK_COUNT-1:0];
  assign init_row  = init_pr[`ALU_IMM_LOG_PR_COUNT-1:`ALU_IMM_LOG_BANK_COUNT];
  assign wb_bank   = wb.pr[`ALU_IMM_LOG_BANK_COUNT-1:0];
  assign wb_row    = wb.pr[`ALU_IMM_LOG_PR_COUNT-1:`ALU_IMM_LOG_BANK_COUNT];

  assign wb_xfer = wb.valid && wb.ready;

  // A busy bank has its read port taken by another pipeline
  assign rd.ack  = rd.req && !bank_busy[rd_bank];
  assign rd.data = regs[rd_bank][rd_row];

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int b = 0; b < `ALU_IMM_BANK_COUNT; b++) begin
        for (int r = 0; r < ROWS; r++) begin
          regs[b][r] <= '0;
        end
      end
    end else begin
      if (init_we) begin
        regs[init_bank][init_row] <= init_data;
      end
      // Writeback comes last so it wins on a clash
      if (wb_xfer) begin
        regs[wb_bank][wb_row] <= wb.data;
      end
    end
  end

  a_ack_needs_req: assert property (
    @(posedge CLK) disable iff (!rst_n)
    rd.ack |-> rd.req
  ) else $error("prf_banks: ack without req");

endmodule

// File: src/alu_imm_exec.sv
/*
  Immediate ALU
  Sign-extends the 12-bit immediate and applies one of nine operations
*/
`timescale 1ns/1ps
`include "alu_imm_params.svh"

module alu_imm_exec
  import alu_imm_pkg::*;
(
  input  alu_op_t op,
  input  word_t   a,
  input  imm12_t  imm12,
  output word_t   result
);

  word_t      imm_ext;
  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign imm_ext = {{(`ALU_IMM_XLEN-12){imm12[11]}}, imm12};
  assign shamt   = imm12[4:0];

  // Both compares use the sign-extended immediate
  assign lt_signed   = $signed(a) < $signed(imm_ext);
  assign lt_unsigned = a < imm_ext;

  always_comb begin
    case (op)
      OP_ADDI:  result = a + imm_ext;
      OP_SLTI:  result = {{(`ALU_IMM_XLEN-1){1'b0}}, lt_signed};
      OP_SLTIU: result = {{(`ALU_IMM_XLEN-1){1'b0}}, lt_unsigned};
      OP_XORI:  result = a ^ imm_ext;
      OP_ORI:   result = a | imm_ext;
      OP_ANDI:  result = a & imm_ext;
      OP_SLLI:  result = a << shamt;
      OP_SRLI:  result = a >> shamt;
      OP_SRAI:  result = word_t'($signed(a) >>> shamt);
      default:  result = '0;
    endcase
  end

endmodule

// File: src/alu_imm_pipeline.sv
/*
  Immediate ALU pipeline
  Issue, operand and writeback stages with valid/ready stalls
*/
`timescale 1ns/1ps
`include "alu_imm_params.svh"

module alu_imm_pipeline
  import alu_imm_pkg::*;
(
  input  logic                                 CLK,
  input  logic                                 rst_n,
  input  logic                                 issue_valid,
  output logic                                 issue_ready,
  input  alu_op_t                              issue_op,
  input  imm12_t                               issue_imm12,
  input  pr_idx_t                              issue_a_pr,
  input  logic                                 issue_a_forward,
  input  logic                                 issue_a_is_zero,
  input  pr_idx_t                              issue_dest_pr,
  input  rob_idx_t                             issue_rob_index,
  input  word_t [`ALU_IMM_BANK_COUNT-1:0]      fwd_data,
  prf_read_if.requester                        rd,
  wb_if.source                                 wb
);

  // Issue stage
  logic     s1_valid;
  alu_op_t  s1_op;
  imm12_t   s1_imm12;
  pr_idx_t  s1_a_pr;
  logic     s1_fwd;
  logic     s1_zero;
  pr_idx_t  s1_dest_pr;
  rob_idx_t s1_rob_index;

  // Operand stage
  logic     s2_valid;
  alu_op_t  s2_op;
  imm12_t   s2_imm12;
  pr_idx_t  s2_a_pr;
  logic     s2_fwd;
  logic     s2_zero;
  pr_idx_t  s2_dest_pr;
  rob_idx_t s2_rob_index;

  // Writeback stage
  logic     s3_valid;
  word_t    s3_data;
  pr_idx_t  s3_pr;
  rob_idx_t s3_rob_index;

  bank_idx_t s2_bank;
  logic      s2_needs_read;
  logic      s2_fire;
  logic      s2_can_accept;
  logic      s1_fire;
  logic      s3_can_accept;
  word_t     operand;
  word_t     alu_result;

  assign s3_can_accept = !s3_valid || wb.ready;

  assign s2_bank       = s2_a_pr[`ALU_IMM_LOG_BANK_COUNT-1:0];
  assign s2_needs_read = s2_valid && !s2_zero && !s2_fwd;
  assign s2_fire       = s2_valid && (!s2_needs_read || rd.ack) && s3_can_accept;
  assign s2_can_accept = !s2_valid || s2_fire;

  assign s1_fire     = s1_valid && s2_can_accept;
  assign issue_ready = !s1_valid || s1_fire;

  assign rd.req = s2_needs_read;
  assign rd.pr  = s2_a_pr;

  // Zero takes priority over forwarding
  always_comb begin
    if (s2_zero) begin
      operand = '0;
    end else if (s2_fwd) begin
      operand = fwd_data[s2_bank];
    end else begin
      operand = rd.data;
    end
  end

  alu_imm_exec u_exec (
    .op     (s2_op),
    .a      (operand),
    .imm12  (s2_imm12),
    .result (alu_result)
  );

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end else begin
      if (issue_ready) begin
        s1_valid <= issue_valid;
      end
      if (s2_can_accept) begin
        s2_valid <= s1_valid;
      end
      if (s3_can_accept) begin
        s3_valid <= s2_fire;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (issue_valid && issue_ready) begin
      s1_op        <= issue_op;
      s1_imm12     <= issue_imm12;
      s1_a_pr      <= issue_a_pr;
      s1_fwd       <= issue_a_forward;
      s1_zero      <= issue_a_is_zero;
      s1_dest_pr   <= issue_dest_pr;
      s1_rob_index <= issue_rob_index;
    end
    if (s1_fire) begin
      s2_op        <= s1_op;
      s2_imm12     <= s1_imm12;
      s2_a_pr      <= s1_a_pr;
      s2_fwd       <= s1_fwd;
      s2_zero      <= s1_zero;
      s2_dest_pr   <= s1_dest_pr;
      s2_rob_index <= s1_rob_index;
    end
    if (s2_fire) begin
      s3_data      <= alu_result;
      s3_pr        <= s2_dest_pr;
      s3_rob_index <= s2_rob_index;
    end
  end

  assign wb.valid     = s3_valid;
  assign wb.data      = s3_data;
  assign wb.pr        = s3_pr;
  assign wb.rob_index = s3_rob_index;

  // Bundle must hold while the consumer stalls
  a_wb_stable: assert property (
    @(posedge CLK) disable iff (!rst_n)
    (wb.valid && !wb.ready) |=>
      (wb.valid && $stable(wb.data) && $stable(wb.pr) && $stable(wb.rob_index))
  ) else $error("alu_imm_pipeline: writeback bundle changed during stall");

  a_req_with_s2: assert property (
    @(posedge CLK) disable iff (!rst_n)
    rd.req |-> s2_valid
  ) else $error("alu_imm_pipeline: read request without operand stage instruction");

  a_wb_idle_after_reset: assert property (
    @(posedge CLK)
    !rst_n |=> !wb.valid
  ) else $error("alu_imm_pipeline: writeback valid right after reset");

endmodule

// File: src/alu_imm_unit.sv
/*
  Immediate ALU unit
  Pipeline and banked register file behind plain issue and writeback ports
*/
`timescale 1ns/1ps
`include "alu_imm_params.svh"

module alu_imm_unit
  import alu_imm_pkg::*;
(
  input  logic                            CLK,
  input  logic                            rst_n,
  input  logic                            issue_valid,
  output logic                            issue_ready,
  input  alu_op_t                         issue_op,
  input  imm12_t                          issue_imm12,
  input  pr_idx_t                         issue_a_pr,
  input  logic                            issue_a_forward,
  input  logic                            issue_a_is_zero,
  input  pr_idx_t                         issue_dest_pr,
  input  rob_idx_t                        issue_rob_index,
  input  word_t [`ALU_IMM_BANK_COUNT-1:0] fwd_data,
  input  logic [`ALU_IMM_BANK_COUNT-1:0]  bank_busy,
  input  logic                            init_we,
  input  pr_idx_t                         init_pr,
  input  word_t                           init_data,
  output logic                            wb_valid,
  input  logic                            wb_ready,
  output word_t                           wb_data,
  output pr_idx_t                         wb_pr,
  output rob_idx_t                        wb_rob_index
);

  prf_read_if rd_bus ();
  wb_if       wb_bus ();

  assign wb_bus.ready = wb_ready;
  assign wb_valid     = wb_bus.valid;
  assign wb_data      = wb_bus.data;
  assign wb_pr        = wb_bus.pr;
  assign wb_rob_index = wb_bus.rob_index;

  alu_imm_pipeline u_pipeline (
    .CLK             (CLK),
    .rst_n           (rst_n),
    .issue_valid     (issue_valid),
    .issue_ready     (issue_ready),
    .issue_op        (issue_op),
    .issue_imm12     (issue_imm12),
    .issue_a_pr      (issue_a_pr),
    .issue_a_forward (issue_a_forward),
    .issue_a_is_zero (issue_a_is_zero),
    .issue_dest_pr   (issue_dest_pr),
    .issue_rob_index (issue_rob_index),
    .fwd_data        (fwd_data),
    .rd              (rd_bus.requester),
    .wb              (wb_bus.source)
  );

  prf_banks u_prf (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .bank_busy (bank_busy),
    .init_we   (init_we),
    .init_pr   (init_pr),
    .init_data (init_data),
    .rd        (rd_bus.responder),
    .wb        (wb_bus.monitor)
  );

endmodule

// File: dv/alu_imm_unit_tb.sv
/*
  Immediate ALU unit testbench
  LFSR stimulus with a shadow register file, in-order result checks and a cycle limit
*/
`timescale 1ns/1ps
`include "alu_imm_params.svh"

module alu_imm_unit_tb
  import alu_imm_pkg::*;
  ();

  localparam int N_BASIC = 36;
  localparam int N_SRC = 16;
  localparam int N_READY = 40;
  localparam int N_BUSY = 40;
  localparam int N_RAW = 16;
  localparam int TOTAL_ISSUES = N_BASIC + N_SRC + N_READY + N_BUSY + N_RAW;
  localparam int CYCLE_LIMIT = 4 * TOTAL_ISSUES + 200;

  logic CLK;
  logic rst_n;
  logic issue_valid;
  logic issue_ready;
  alu_op_t issue_op;
  imm12_t issue_imm12;
  pr_idx_t issue_a_pr;
  logic issue_a_forward;
  logic issue_a_is_zero;
  pr_idx_t issue_dest_pr;
  rob_idx_t issue_rob_index;
  word_t [`ALU_IMM_BANK_COUNT-1:0] fwd_data;
  logic [`ALU_IMM_BANK_COUNT-1:0] bank_busy;
  logic init_we;
  pr_idx_t init_pr;
  word_t init_data;
  logic wb_valid;
  logic wb_ready;
  word_t wb_data;
  pr_idx_t wb_pr;
  rob_idx_t wb_rob_index;

  logic [15:0] lfsr_state;
  word_t shadow [`ALU_IMM_PR_COUNT];
  int pending_cnt [`ALU_IMM_PR_COUNT];
  word_t exp_data_q [$];
  pr_idx_t exp_pr_q [$];
  rob_idx_t exp_rob_q [$];
  int issue_cycle_q [$];
  word_t drv_exp_data;
  rob_idx_t next_rob;
  int cycle;
  logic rand_ready;
  logic rand_busy;
  logic check_latency;
  logic saw_full;
  logic stall_seen;
  word_t held_data;
  pr_idx_t held_pr;
  rob_idx_t held_rob;

  alu_imm_unit u_dut (.*);

  always #10 CLK = ~CLK;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic word_t ref_alu(input alu_op_t op, input word_t a, input imm12_t imm);
    word_t sx;
    int sh;
    logic [63:0] wide;
    sx = {{20{imm[11]}}, imm};
    sh = imm[4:0];
    wide = {{32{a[31]}}, a} >> sh;
    case (op)
      OP_ADDI:  return a + sx;
      OP_SLTI:  return ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
      OP_SLTIU: return (a < sx) ? 32'd1 : 32'd0;
      OP_XORI:  return a ^ sx;
      OP_ORI:   return a | sx;
      OP_ANDI:  return a & sx;
      OP_SLLI:  return a << sh;
      OP_SRLI:  return a >> sh;
      OP_SRAI:  return wide[31:0];
      default:  return 32'd0;
    endcase
  endfunction

  task automatic fail_run(input string why);
    $display("Error: %s", why);
    $display("Testbench failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
      $display("Testbench failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Advance to the next falling edge and redraw back-pressure and bank busy
  task automatic step_cycle();
    @(negedge CLK);
    wb_ready = rand_ready ? rand_bits(1) : 1'b1;
    bank_busy = rand_busy ? rand_bits(`ALU_IMM_BANK_COUNT) : '0;
  endtask

  task automatic issue_instr(input alu_op_t op, input imm12_t imm, input pr_idx_t a_pr,
                             input logic fwd, input logic zero, input pr_idx_t dest);
    word_t operand;
    logic use_fwd;
    logic done;
    // A source still owed a writeback goes through the forwarding bus instead
    use_fwd = fwd || (!zero && pending_cnt[a_pr] != 0);
    if (zero) begin
      operand = '0;
    end else if (use_fwd) begin
      operand = fwd_data[a_pr[`ALU_IMM_LOG_BANK_COUNT-1:0]];
    end else begin
      operand = shadow[a_pr];
    end
    drv_exp_data = ref_alu(op, operand, imm);
    issue_valid = 1'b1;
    issue_op = op;
    issue_imm12 = imm;
    issue_a_pr = a_pr;
    issue_a_forward = use_fwd;
    issue_a_is_zero = zero;
    issue_dest_pr = dest;
    issue_rob_index = next_rob;
    done = 1'b0;
    while (!done) begin
      @(posedge CLK);
      done = issue_ready;
      step_cycle();
    end
    issue_valid = 1'b0;
    next_rob = next_rob + 1'b1;
  endtask

  task automatic run_random(input int count, input logic with_flags, input logic cycle_ops);
    alu_op_t op;
    logic fwd;
    logic zero;
    for (int i = 0; i < count; i++) begin
      op = cycle_ops ? alu_op_t'(i % 12) : alu_op_t'(rand_bits(4) % 9);
      fwd = with_flags ? rand_bits(1) : 1'b0;
      zero = with_flags ? rand_bits(1) : 1'b0;
      issue_instr(op, rand_bits(12), rand_bits(6), fwd, zero, rand_bits(6));
    end
  endtask

  task automatic drain();
    while (exp_data_q.size() != 0) begin
      step_cycle();
    end
  endtask

  always @(posedge CLK) begin : monitor
    int lat;
    word_t exp_d;
    pr_idx_t exp_p;
    rob_idx_t exp_r;
    if (rst_n) begin
      if (cycle >= CYCLE_LIMIT) begin
        fail_run("run exceeded the cycle limit without finishing");
      end
      if (stall_seen) begin
        check_value("wb_valid", wb_valid, 1'b1);
        check_value("wb_data", wb_data, held_data);
        check_value("wb_pr", wb_pr, held_pr);
        check_value("wb_rob_index", wb_rob_index, held_rob);
      end
      stall_seen = wb_valid && !wb_ready;
      held_data = wb_data;
      held_pr = wb_pr;
      held_rob = wb_rob_index;
      if (!issue_ready && !wb_ready) begin
        saw_full = 1'b1;
      end
      if (init_we) begin
        shadow[init_pr] = init_data;
      end
      if (wb_valid && wb_ready) begin
        if (exp_data_q.size() == 0) begin
          fail_run("writeback seen with no instruction outstanding");
        end else begin
          exp_d = exp_data_q.pop_front();
          exp_p = exp_pr_q.pop_front();
          exp_r = exp_rob_q.pop_front();
          check_value("wb_data", wb_data, exp_d);
          check_value("wb_pr", wb_pr, exp_p);
          check_value("wb_rob_index", wb_rob_index, exp_r);
          lat = cycle - issue_cycle_q.pop_front();
          if (check_latency) begin
            check_value("latency", lat, 3);
          end
          shadow[exp_p] = exp_d;
          pending_cnt[exp_p]--;
        end
      end
      if (issue_valid && issue_ready) begin
        exp_data_q.push_back(drv_exp_data);
        exp_pr_q.push_back(issue_dest_pr);
        exp_rob_q.push_back(issue_rob_index);
        issue_cycle_q.push_back(cycle);
        pending_cnt[issue_dest_pr]++;
      end
      cycle++;
    end
  end

  initial begin
    pr_idx_t dest;
    CLK = 1'b0;
    rst_n = 1'b0;
    lfsr_state = 16'd99;
    issue_valid = 1'b0;
    issue_op = OP_ADDI;
    issue_imm12 = '0;
    issue_a_pr = '0;
    issue_a_forward = 1'b0;
    issue_a_is_zero = 1'b0;
    issue_dest_pr = '0;
    issue_rob_index = '0;
    bank_busy = '0;
    init_we = 1'b0;
    init_pr = '0;
    init_data = '0;
    wb_ready = 1'b1;
    next_rob = '0;
    cycle = 0;
    rand_ready = 1'b0;
    rand_busy = 1'b0;
    check_latency = 1'b0;
    saw_full = 1'b0;
    stall_seen = 1'b0;
    for (int b = 0; b < `ALU_IMM_BANK_COUNT; b++) begin
      fwd_data[b] = rand_bits(32);
    end
    for (int p = 0; p < `ALU_IMM_PR_COUNT; p++) begin
      shadow[p] = '0;
      pending_cnt[p] = 0;
    end
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    rst_n = 1'b1;
    check_value("wb_valid", wb_valid, 1'b0);
    check_value("issue_ready", issue_ready, 1'b1);

    for (int p = 0; p < `ALU_IMM_PR_COUNT; p++) begin
      init_we = 1'b1;
      init_pr = p;
      init_data = rand_bits(32);
      step_cycle();
    end
    init_we = 1'b0;

    // Every code back to back at fixed latency
    check_latency = 1'b1;
    run_random(N_BASIC, 1'b0, 1'b1);
    drain();
    check_latency = 1'b0;

    // Zero and forwarded sources with new bus values set while idle
    for (int b = 0; b < `ALU_IMM_BANK_COUNT; b++) begin
      fwd_data[b] = rand_bits(32);
    end
    run_random(N_SRC, 1'b1, 1'b0);
    drain();

    rand_ready = 1'b1;
    run_random(N_READY, 1'b1, 1'b0);
    drain();
    rand_ready = 1'b0;

    rand_busy = 1'b1;
    run_random(N_BUSY, 1'b0, 1'b0);
    drain();

    // Write a register and read it back through the register file
    for (int k = 0; k < N_RAW / 2; k++) begin
      dest = rand_bits(4);
      issue_instr(OP_ADDI, rand_bits(12), '0, 1'b0, 1'b1, dest);
      drain();
      issue_instr(OP_ORI, 12'h000, dest, 1'b0, 1'b0, rand_bits(6));
    end
    drain();
    rand_busy = 1'b0;

    if (!saw_full) begin
      fail_run("issue_ready never fell while writeback was stalled");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

// File: build.f
+incdir+src
src/alu_imm_pkg.sv
src/prf_read_if.sv
src/wb_if.sv
src/prf_banks.sv
src/alu_imm_exec.sv
src/alu_imm_pipeline.sv
src/alu_imm_unit.sv
dv/alu_imm_unit_tb.sv
